/* rtl/avmm_pkg.sv */
// Avalon-MM memory subsystem shared definitions
// Bus widths, memory geometry, request/response structs and enums

`default_nettype none

package avmm_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH      = 8;
    localparam int DATA_WIDTH      = 32;
    localparam int BE_WIDTH        = DATA_WIDTH / 8;
    localparam int BURST_CNT_WIDTH = 4;

    // Memory depth in words, matching the full word address space
    localparam int MEM_WORDS       = 256;

    // Register stages placed between the host port and the memory slave
    localparam int N_REG_STAGES    = 2;

    // Avalon response codes, only the two used here are named
    typedef enum logic [1:0] {
        RESP_OKAY        = 2'b00,
        RESP_DECODEERROR = 2'b11
    } avmm_resp_e;

    // Command travelling from the host towards the memory
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [ADDR_WIDTH-1:0]      address;
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0]      writedata;
        logic [BE_WIDTH-1:0]        byteenable;
    } avmm_req_t;

    // Read response travelling back to the host
    typedef struct packed {
        logic                  readdatavalid;
        logic [DATA_WIDTH-1:0] readdata;
        avmm_resp_e            response;
    } avmm_rsp_t;

    // Memory slave control states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_BURST,
        ST_READ_BURST
    } burst_state_e;

endpackage

`default_nettype wire

/* rtl/avmm_bridge.sv */
// Avalon-MM register stage
// The command path goes through an output register backed by a one-entry
// skid register, so upstream waitrequest comes straight from a flop.
// The response path is a plain one-cycle register.

`timescale 1ns/1ps
`default_nettype none

module avmm_bridge
    import avmm_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,

    // Upstream side, facing the host
    input  wire avmm_req_t up_req,
    output logic           up_waitrequest,
    output avmm_rsp_t      up_rsp,

    // Downstream side, facing the memory
    output avmm_req_t      dn_req,
    input  wire            dn_waitrequest,
    input  wire avmm_rsp_t dn_rsp
);

    avmm_req_t out_req;
    avmm_req_t skid_req;
    logic      skid_valid;
    avmm_rsp_t rsp_q;

    logic      up_fire;
    logic      out_busy;

    // A command is taken from upstream whenever the skid is empty
    assign up_fire  = (up_req.read | up_req.write) & ~up_waitrequest;

    // The output register is stuck while it holds a command the
    // downstream side has not taken yet
    assign out_busy = (out_req.read | out_req.write) & dn_waitrequest;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_req    <= '0;
            skid_req   <= '0;
            skid_valid <= 1'b0;
        end
        else if (!out_busy)
        begin
            // The output register is free, so the skid entry drains first
            // to keep commands in order
            if (skid_valid)
            begin
                out_req    <= skid_req;
                skid_valid <= 1'b0;
            end
            else
            begin
                // With the skid empty upstream sees no stall, so anything
                // presented here is a real transfer or an idle cycle
                out_req <= up_req;
            end
        end
        else if (up_fire)
        begin
            // Downstream stalled while a new command arrived, park it
            skid_req   <= up_req;
            skid_valid <= 1'b1;
        end
    end

    // Stall upstream only while the skid entry is occupied
    assign up_waitrequest = skid_valid;
    assign dn_req         = out_req;

    // Responses cannot be back-pressured, one register is all they need
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_q <= '0;
        end
        else
        begin
            rsp_q <= dn_rsp;
        end
    end

    assign up_rsp = rsp_q;

endmodule

`default_nettype wire

/* rtl/avmm_pipe.sv */
// Avalon-MM pipeline chain
// Places a configurable number of register stages between the host port
// and the memory port, or connects them directly when the count is zero

`timescale 1ns/1ps
`default_nettype none

module avmm_pipe
    import avmm_pkg::*;
#(
    parameter int N_REG_STAGES = 1
)
(
    input  wire            clk,
    input  wire            arst_n,

    input  wire avmm_req_t host_req,
    output logic           host_waitrequest,
    output avmm_rsp_t      host_rsp,

    output avmm_req_t      mem_req,
    input  wire            mem_waitrequest,
    input  wire avmm_rsp_t mem_rsp
);

    generate
        if (N_REG_STAGES == 0)
        begin : g_wires
            assign mem_req          = host_req;
            assign host_waitrequest = mem_waitrequest;
            assign host_rsp         = mem_rsp;
        end
        else
        begin : g_regs
            // Set 0 is the host port and the last set is the memory port
            avmm_req_t stage_req  [0:N_REG_STAGES];
            logic      stage_wait [0:N_REG_STAGES];
            avmm_rsp_t stage_rsp  [0:N_REG_STAGES];

            assign stage_req[0]     = host_req;
            assign host_waitrequest = stage_wait[0];
            assign host_rsp         = stage_rsp[0];

            // Bridge s sits between set s-1 and set s
            for (genvar s = 1; s <= N_REG_STAGES; s++)
            begin : g_stage
                avmm_bridge i_bridge (
                    .clk            (clk),
                    .arst_n         (arst_n),
                    .up_req         (stage_req[s-1]),
                    .up_waitrequest (stage_wait[s-1]),
                    .up_rsp         (stage_rsp[s-1]),
                    .dn_req         (stage_req[s]),
                    .dn_waitrequest (stage_wait[s]),
                    .dn_rsp         (stage_rsp[s])
                );
            end

            assign mem_req                  = stage_req[N_REG_STAGES];
            assign stage_wait[N_REG_STAGES] = mem_waitrequest;
            assign stage_rsp[N_REG_STAGES]  = mem_rsp;
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/avmm_burst_fsm.sv */
// Memory slave control FSM
// Accepts Avalon commands, drives waitrequest and sequences the beats
// of write and read bursts through the beat counter

`timescale 1ns/1ps
`default_nettype none

module avmm_burst_fsm
    import avmm_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,

    input  wire avmm_req_t req,
    output logic           waitrequest,

    // Beat counter control
    output logic           beat_load,
    output logic           beat_step,
    input  wire            last_beat,

    // Per-beat strobes to the storage array
    output logic           wr_en,
    output logic           rd_en
);

    burst_state_e state_q;
    burst_state_e state_d;

    always_comb
    begin
        state_d     = state_q;
        waitrequest = 1'b0;
        beat_load   = 1'b0;
        beat_step   = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;

        case (state_q)
            ST_IDLE:
            begin
                if (req.write)
                begin
                    // The first write beat lands in the acceptance cycle,
                    // so the counter is loaded already stepped past it
                    beat_load = 1'b1;
                    beat_step = 1'b1;
                    wr_en     = 1'b1;
                    // Counter is not loaded yet, use the live burstcount
                    if (req.burstcount > BURST_CNT_WIDTH'(1))
                    begin
                        state_d = ST_WRITE_BURST;
                    end
                end
                else if (req.read)
                begin
                    // Read beats start in the next cycle from index 0
                    beat_load = 1'b1;
                    state_d   = ST_READ_BURST;
                end
            end

            ST_WRITE_BURST:
            begin
                // Idle cycles between write beats are allowed
                if (req.write)
                begin
                    beat_step = 1'b1;
                    wr_en     = 1'b1;
                    if (last_beat)
                    begin
                        state_d = ST_IDLE;
                    end
                end
            end

            ST_READ_BURST:
            begin
                // Further commands wait until every read beat is issued
                waitrequest = 1'b1;
                beat_step   = 1'b1;
                rd_en       = 1'b1;
                if (last_beat)
                begin
                    state_d = ST_IDLE;
                end
            end

            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/avmm_beat_counter.sv */
// Burst beat counter
// Holds the burst base address and beat index and gives the beat address,
// the last-beat flag and an error for beats past the memory top

`timescale 1ns/1ps
`default_nettype none

module avmm_beat_counter
    import avmm_pkg::*;
(
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             load,
    input  wire                             step,
    input  wire logic [ADDR_WIDTH-1:0]      base_addr,
    input  wire logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic      [ADDR_WIDTH-1:0]      beat_addr,
    output logic                            last_beat,
    output logic                            out_of_range
);

    logic [ADDR_WIDTH-1:0]      base_q;
    logic [BURST_CNT_WIDTH-1:0] bc_q;
    logic [BURST_CNT_WIDTH-1:0] idx_q;
    logic [ADDR_WIDTH:0]        beat_sum;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bc_q  <= '0;
            idx_q <= '0;
        end
        else if (load)
        begin
            bc_q  <= burstcount;
            // Load and step together means beat 0 is consumed right away
            idx_q <= step ? BURST_CNT_WIDTH'(1) : '0;
        end
        else if (step)
        begin
            idx_q <= idx_q + BURST_CNT_WIDTH'(1);
        end
    end

    // Base address is payload and only matters after a load
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            base_q <= base_addr;
        end
    end

    // One extra bit catches the carry out of the top word
    assign beat_sum     = {1'b0, base_q} + (ADDR_WIDTH + 1)'(idx_q);
    assign beat_addr    = beat_sum[ADDR_WIDTH-1:0];
    assign out_of_range = beat_sum[ADDR_WIDTH];
    assign last_beat    = (idx_q == bc_q - BURST_CNT_WIDTH'(1));

endmodule

`default_nettype wire

/* rtl/avmm_mem_array.sv */
// Byte-enabled word storage for the memory slave
// Writes only the enabled bytes of in-range beats and returns read data
// one cycle after the read strobe, with a decode error past the top

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_array
    import avmm_pkg::*;
(
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        wr_en,
    input  wire                        rd_en,
    input  wire logic [ADDR_WIDTH-1:0] addr,
    input  wire                        out_of_range,
    input  wire logic [DATA_WIDTH-1:0] writedata,
    input  wire logic [BE_WIDTH-1:0]   byteenable,
    output avmm_rsp_t                  rsp
);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic                  rvalid_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    avmm_resp_e            resp_q;

    // Write beats that run past the top are dropped here
    always_ff @(posedge clk)
    begin
        if (wr_en && !out_of_range)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (byteenable[b])
                begin
                    mem[addr][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

    // Read data and response code, zero data for a decode error
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rdata_q <= out_of_range ? '0 : mem[addr];
            resp_q  <= out_of_range ? RESP_DECODEERROR : RESP_OKAY;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rvalid_q <= 1'b0;
        end
        else
        begin
            rvalid_q <= rd_en;
        end
    end

    assign rsp = '{readdatavalid: rvalid_q, readdata: rdata_q, response: resp_q};

endmodule

`default_nettype wire

/* rtl/avmm_mem_sys.sv */
// Avalon-MM memory subsystem top level
// Host port through a register stage chain into a burst-capable
// on-chip memory slave

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_sys
    import avmm_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,
    input  wire avmm_req_t host_req,
    output logic           host_waitrequest,
    output avmm_rsp_t      host_rsp
);

    avmm_req_t             mem_req;
    logic                  mem_waitrequest;
    avmm_rsp_t             mem_rsp;

    logic                  beat_load;
    logic                  beat_step;
    logic                  wr_en;
    logic                  rd_en;
    logic                  last_beat;
    logic                  cnt_oor;
    logic [ADDR_WIDTH-1:0] beat_addr;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_oor;

    avmm_pipe #(
        .N_REG_STAGES (N_REG_STAGES)
    ) i_pipe (
        .clk              (clk),
        .arst_n           (arst_n),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .host_rsp         (host_rsp),
        .mem_req          (mem_req),
        .mem_waitrequest  (mem_waitrequest),
        .mem_rsp          (mem_rsp)
    );

    avmm_burst_fsm i_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (mem_req),
        .waitrequest (mem_waitrequest),
        .beat_load   (beat_load),
        .beat_step   (beat_step),
        .last_beat   (last_beat),
        .wr_en       (wr_en),
        .rd_en       (rd_en)
    );

    avmm_beat_counter i_counter (
        .clk          (clk),
        .arst_n       (arst_n),
        .load         (beat_load),
        .step         (beat_step),
        .base_addr    (mem_req.address),
        .burstcount   (mem_req.burstcount),
        .beat_addr    (beat_addr),
        .last_beat    (last_beat),
        .out_of_range (cnt_oor)
    );

    // The acceptance cycle uses the request address, which is always in
    // range; later beats come from the counter
    assign mem_addr = beat_load ? mem_req.address : beat_addr;
    assign mem_oor  = beat_load ? 1'b0 : cnt_oor;

    avmm_mem_array i_array (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .addr         (mem_addr),
        .out_of_range (mem_oor),
        .writedata    (mem_req.writedata),
        .byteenable   (mem_req.byteenable),
        .rsp          (mem_rsp)
    );

endmodule

`default_nettype wire

/* tb/avmm_mem_sys_properties.sv */
// Avalon-MM host port rules for the memory subsystem
// Checks request stability under waitrequest, read response accounting
// and the port state right after reset

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_sys_properties
    import avmm_pkg::*;
(
    input wire            clk,
    input wire            arst_n,
    input wire avmm_req_t host_req,
    input wire            host_waitrequest,
    input wire avmm_rsp_t host_rsp
);

    logic [15:0] rd_pending;
    logic        rd_accept;

    // A read transfer adds burstcount beats, each readdatavalid removes one
    assign rd_accept = host_req.read & ~host_waitrequest;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_pending <= '0;
        end
        else
        begin
            rd_pending <= rd_pending + (rd_accept ? 16'(host_req.burstcount) : 16'd0)
                          - (host_rsp.readdatavalid ? 16'd1 : 16'd0);
        end
    end

    // A stalled command must not change until it is taken
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (host_req.read | host_req.write) && host_waitrequest |=> $stable(host_req))
        else $error("request changed while waitrequest was high");

    a_rdv_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        host_rsp.readdatavalid |-> rd_pending != 16'd0)
        else $error("readdatavalid without an outstanding read beat");

    // First cycle out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(arst_n) |-> !host_waitrequest && !host_rsp.readdatavalid)
        else $error("waitrequest or readdatavalid high right after reset");

endmodule

bind avmm_mem_sys avmm_mem_sys_properties i_props (
    .clk              (clk),
    .arst_n           (arst_n),
    .host_req         (host_req),
    .host_waitrequest (host_waitrequest),
    .host_rsp         (host_rsp)
);

`default_nettype wire

/* tb/avmm_mem_sys_tb.sv */
// Testbench for the Avalon-MM memory subsystem
// Reads bursts from a case file, drives the host port, predicts read data
// from a reference memory and checks every readdatavalid beat in order

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_sys_tb
    import avmm_pkg::*;
();

    logic      clk;
    logic      arst_n;
    avmm_req_t host_req;
    logic      host_waitrequest;
    avmm_rsp_t host_rsp;

    // Case table, one entry per line of the case file
    string                      c_name [$];
    bit                         c_is_wr [$];
    logic [ADDR_WIDTH-1:0]      c_addr [$];
    logic [BURST_CNT_WIDTH-1:0] c_bc [$];
    logic [BE_WIDTH-1:0]        c_be [$];
    logic [DATA_WIDTH-1:0]      c_data [$];
    avmm_resp_e                 c_resp [$];

    // Expected read beats, in the order the DUT must return them
    logic [DATA_WIDTH-1:0] exp_data_q [$];
    avmm_resp_e            exp_resp_q [$];
    int                    exp_case_q [$];
    bit                    exp_last_q [$];

    logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];

    integer seed;
    int     total_beats;
    int     timeout_limit;
    bit     limit_ready;
    int     load_errors;
    int     error_count;
    int     check_count;
    int     errors_at_case_start;

    avmm_mem_sys i_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .host_rsp         (host_rsp)
    );

    // 20 ns clock period
    always #10 clk = ~clk;

    // Expands the four byte enables into a data mask
    function automatic logic [DATA_WIDTH-1:0] be_mask(input logic [BE_WIDTH-1:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic check_data(input int id, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        check_count++;
        if (act !== exp)
        begin
            $display("mismatch %s data expected %h actual %h", c_name[id], exp, act);
            error_count++;
        end
    endtask

    task automatic check_resp(input int id, input avmm_resp_e exp, input avmm_resp_e act);
        check_count++;
        if (act !== exp)
        begin
            $display("mismatch %s response expected %0h actual %0h", c_name[id], exp, act);
            error_count++;
        end
    endtask

    // Fills the case table; lines starting with # are comments
    task automatic load_cases();
        integer      fd;
        int          status;
        string       line;
        string       name;
        string       op;
        int unsigned addr_v;
        int unsigned bc_v;
        int unsigned be_v;
        int unsigned data_v;
        int unsigned resp_v;
        fd = $fopen("tb/avmm_cases.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open the case file tb/avmm_cases.txt");
            load_errors++;
            return;
        end
        while ($feof(fd) == 0)
        begin
            line = "";
            status = $fgets(line, fd);
            if (line.len() == 0 || line.getc(0) == 8'h23)
            begin
                continue;
            end
            status = $sscanf(line, "%s %s %h %h %h %h %h",
                             name, op, addr_v, bc_v, be_v, data_v, resp_v);
            if (status <= 0)
            begin
                continue;
            end
            if (status != 7 || (op != "W" && op != "R") || bc_v < 1 || bc_v > 8)
            begin
                $display("error: malformed case line: %s", line);
                load_errors++;
                continue;
            end
            c_name.push_back(name);
            c_is_wr.push_back(op == "W");
            c_addr.push_back(ADDR_WIDTH'(addr_v));
            c_bc.push_back(BURST_CNT_WIDTH'(bc_v));
            c_be.push_back(BE_WIDTH'(be_v));
            c_data.push_back(DATA_WIDTH'(data_v));
            c_resp.push_back(avmm_resp_e'(2'(resp_v)));
            total_beats = total_beats + int'(bc_v);
        end
        $fclose(fd);
        if (c_name.size() == 0)
        begin
            $display("error: no cases were read from the case file");
            load_errors++;
        end
    endtask

    // Presents one transfer and holds it until waitrequest lets it through
    task automatic send_beat(input avmm_req_t beat);
        logic taken;
        taken = 1'b0;
        host_req = beat;
        while (!taken)
        begin
            // waitrequest is a flop output, so mid-cycle it shows the stall
            // that applies at the coming edge
            @(negedge clk);
            taken = !host_waitrequest;
            @(posedge clk);
            #2;
        end
    endtask

    // Issues one burst after 0 to 3 idle cycles and records its expectations
    task automatic run_case(input int i);
        avmm_req_t             beat;
        logic [ADDR_WIDTH:0]   word;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] mask;
        int                    idle_cycles;
        idle_cycles = $random(seed) & 3;
        host_req = '0;
        repeat (idle_cycles)
        begin
            @(posedge clk);
            #2;
        end
        beat = '0;
        beat.address = c_addr[i];
        beat.burstcount = c_bc[i];
        beat.byteenable = c_be[i];
        mask = be_mask(c_be[i]);
        for (int b = 0; b < int'(c_bc[i]); b++)
        begin
            // Beat address with a carry bit; a set carry is past the top word
            word = {1'b0, c_addr[i]} + (ADDR_WIDTH + 1)'(b);
            if (c_is_wr[i])
            begin
                wdata = c_data[i] + DATA_WIDTH'(b);
                if (!word[ADDR_WIDTH])
                begin
                    ref_mem[word[ADDR_WIDTH-1:0]] =
                        (ref_mem[word[ADDR_WIDTH-1:0]] & ~mask) | (wdata & mask);
                end
                beat.write = 1'b1;
                beat.writedata = wdata;
                send_beat(beat);
            end
            else
            begin
                exp_data_q.push_back(word[ADDR_WIDTH] ? '0 : ref_mem[word[ADDR_WIDTH-1:0]]);
                // The last beat takes its response from the case file
                if (b == int'(c_bc[i]) - 1)
                    exp_resp_q.push_back(c_resp[i]);
                else
                    exp_resp_q.push_back(word[ADDR_WIDTH] ? RESP_DECODEERROR : RESP_OKAY);
                exp_case_q.push_back(i);
                exp_last_q.push_back(b == int'(c_bc[i]) - 1);
            end
        end
        if (c_is_wr[i])
        begin
            $display("case %-14s write %0d beats done", c_name[i], c_bc[i]);
        end
        else
        begin
            // A read burst is a single transfer
            beat.read = 1'b1;
            send_beat(beat);
        end
    endtask

    // Pairs each readdatavalid beat with the oldest expected beat
    always @(negedge clk)
    begin : rsp_monitor
        int id;
        bit last;
        int case_errors;
        if (arst_n && host_rsp.readdatavalid)
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("error: readdatavalid arrived with no read beat outstanding");
                error_count++;
            end
            else
            begin
                id = exp_case_q.pop_front();
                last = exp_last_q.pop_front();
                check_data(id, exp_data_q.pop_front(), host_rsp.readdata);
                check_resp(id, exp_resp_q.pop_front(), host_rsp.response);
                if (last)
                begin
                    case_errors = error_count - errors_at_case_start;
                    errors_at_case_start = error_count;
                    $display("case %-14s read  %0d beats, %0d errors",
                             c_name[id], c_bc[id], case_errors);
                end
            end
        end
    end

    initial
    begin : watchdog
        int cycle_count;
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < timeout_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles, %0d read beats never returned",
                 cycle_count, exp_data_q.size());
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin : stimulus
        int total_errors;
        clk = 1'b0;
        arst_n = 1'b0;
        host_req = '0;
        seed = 32'h605f2dcc;
        total_beats = 0;
        load_errors = 0;
        error_count = 0;
        check_count = 0;
        errors_at_case_start = 0;
        load_cases();
        // Each beat may cost a pass through both stage directions plus stalls
        timeout_limit = total_beats * (2 * N_REG_STAGES + 6) + 200;
        limit_ready = 1'b1;

        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(posedge clk);
        #2;

        for (int i = 0; i < c_name.size(); i++)
        begin
            run_case(i);
        end
        host_req = '0;

        // Let the last read beats drain, then watch a little for stray ones
        while (exp_data_q.size() != 0)
        begin
            @(posedge clk);
        end
        repeat (2 * N_REG_STAGES + 4) @(posedge clk);

        total_errors = error_count + load_errors;
        $display("cases %0d, checks %0d, errors %0d", c_name.size(), check_count, total_errors);
        if (total_errors == 0 && check_count > 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/avmm_cases.txt */
# name op(W/R) address burstcount byteenable first_data last_resp
# numbers in hex; last_resp is 0 for OKAY and 3 for DECODEERROR
single_wr      W 10 1 f 12345678 0
single_rd      R 10 1 f 00000000 0
burst_wr       W 40 8 f a0000000 0
burst_rd       R 40 8 f 00000000 0
part_base_wr   W 80 4 f 11223344 0
part_lo_wr     W 80 1 3 aaaabbbb 0
part_hi_wr     W 81 2 c ccccdddd 0
part_rd        R 80 4 f 00000000 0
top_wr         W fc 8 f 5a5a0000 0
top_rd         R fc 8 f 00000000 3
top_low_rd     R fc 4 f 00000000 0
b2b_wr         W c0 8 f c0de0000 0
b2b_rd0        R c0 8 f 00000000 0
b2b_rd1        R c4 4 f 00000000 0
b2b_rd2        R 40 8 f 00000000 0
b2b_rd3        R 10 1 f 00000000 0
b2b_rd4        R fe 3 f 00000000 3
b2b_rd5        R 80 2 f 00000000 0

/* files.f */
rtl/avmm_pkg.sv
rtl/avmm_bridge.sv
rtl/avmm_pipe.sv
rtl/avmm_burst_fsm.sv
rtl/avmm_beat_counter.sv
rtl/avmm_mem_array.sv
rtl/avmm_mem_sys.sv
tb/avmm_mem_sys_properties.sv
tb/avmm_mem_sys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the Avalon-MM memory subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module avmm_mem_sys_tb \
    -f files.f

# The simulator status is kept so its output still reaches the search
sim_status=0
sim_output="$(./obj_dir/Vavmm_mem_sys_tb 2>&1)" || sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -eq 0 ] && printf '%s\n' "$sim_output" | grep -qx 'Result: PASSED'; then
    exit 0
fi
exit 1
